//--- hw/dispatch.sv
`timescale 1ns/1ps

module dispatch
    import ooo_pkg::*;
(
    // in-order issue port
    input  logic    issue_valid_i,
    input  alu_op_t issue_op_i,
    input  reg_id_t issue_rd_i,
    input  reg_id_t issue_rs1_i,
    input  reg_id_t issue_rs2_i,
    input  word_t   issue_imm_i,
    output logic    issue_stall_o,

    // register file lookup
    output reg_id_t rf_rs1_o,
    output reg_id_t rf_rs2_o,
    input  word_t   rf_vj_i,
    input  word_t   rf_vk_i,
    input  tag_t    rf_qj_i,
    input  tag_t    rf_qk_i,

    // rob lookup and allocation
    input  logic    rob_qj_done_i,
    input  logic    rob_qk_done_i,
    input  word_t   rob_qj_val_i,
    input  word_t   rob_qk_val_i,
    input  logic    rob_full_i,
    input  tag_t    rob_tag_i,
    output logic    alloc_o,
    output reg_id_t alloc_rd_o,

    // station load bus
    input  rs_sel_t rs_busy_i,
    output rs_sel_t rs_load_o,
    output alu_op_t rs_op_o,
    output word_t   rs_vj_o,
    output word_t   rs_vk_o,
    output tag_t    rs_qj_o,
    output tag_t    rs_qk_o,
    output tag_t    rs_tag_o
);

    rs_sel_t free_sel;
    logic    is_li;

    assign is_li = (issue_op_i == OP_LI);

    // lowest clear bit of the busy vector
    assign free_sel = ~rs_busy_i & (rs_busy_i + rs_sel_t'(1));

    assign issue_stall_o = rob_full_i | (&rs_busy_i);
    assign alloc_o       = issue_valid_i & ~issue_stall_o;
    assign alloc_rd_o    = issue_rd_i;
    assign rs_load_o     = alloc_o ? free_sel : '0;

    // li has no source registers, look up x0 so nothing stalls on them
    assign rf_rs1_o = is_li ? '0 : issue_rs1_i;
    assign rf_rs2_o = is_li ? '0 : issue_rs2_i;

    assign rs_op_o  = issue_op_i;
    assign rs_tag_o = rob_tag_i;

    always_comb begin
        rs_vj_o = rf_vj_i;
        rs_qj_o = rf_qj_i;
        rs_vk_o = rf_vk_i;
        rs_qk_o = rf_qk_i;
        // producer finished but not yet committed, take its value from the rob
        if (rf_qj_i != '0 && rob_qj_done_i) begin
            rs_vj_o = rob_qj_val_i;
            rs_qj_o = '0;
        end
        if (rf_qk_i != '0 && rob_qk_done_i) begin
            rs_vk_o = rob_qk_val_i;
            rs_qk_o = '0;
        end
        if (is_li) begin
            rs_vj_o = issue_imm_i;
            rs_qj_o = '0;
            rs_vk_o = '0;
            rs_qk_o = '0;
        end
    end

endmodule : dispatch

//--- hw/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    issue_valid_i,
    input  alu_op_t issue_op_i,
    input  reg_id_t issue_rd_i,
    input  reg_id_t issue_rs1_i,
    input  reg_id_t issue_rs2_i,
    input  word_t   issue_imm_i,
    output logic    issue_stall_o,

    output logic    commit_valid_o,
    output reg_id_t commit_rd_o,
    output tag_t    commit_tag_o,
    output word_t   commit_value_o
);

    // register file lookup
    reg_id_t rf_rs1;
    reg_id_t rf_rs2;
    word_t   rf_vj;
    word_t   rf_vk;
    tag_t    rf_qj;
    tag_t    rf_qk;

    // rob lookup and allocation
    logic    rob_qj_done;
    logic    rob_qk_done;
    word_t   rob_qj_val;
    word_t   rob_qk_val;
    logic    rob_full;
    tag_t    rob_tag;
    logic    alloc;
    reg_id_t alloc_rd;

    // station load bus
    rs_sel_t rs_busy;
    rs_sel_t rs_load;
    alu_op_t rs_op;
    word_t   rs_vj;
    word_t   rs_vk;
    tag_t    rs_qj;
    tag_t    rs_qk;
    tag_t    rs_tag;

    // station results and arbitration
    rs_sel_t st_ready;
    word_t   st_result [`NUM_RS];
    tag_t    st_tag [`NUM_RS];
    rs_sel_t grant;

    logic    cdb_valid;
    tag_t    cdb_tag;
    word_t   cdb_value;

    dispatch u_dispatch (
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_rd_i    (issue_rd_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_imm_i   (issue_imm_i),
        .issue_stall_o (issue_stall_o),
        .rf_rs1_o      (rf_rs1),
        .rf_rs2_o      (rf_rs2),
        .rf_vj_i       (rf_vj),
        .rf_vk_i       (rf_vk),
        .rf_qj_i       (rf_qj),
        .rf_qk_i       (rf_qk),
        .rob_qj_done_i (rob_qj_done),
        .rob_qk_done_i (rob_qk_done),
        .rob_qj_val_i  (rob_qj_val),
        .rob_qk_val_i  (rob_qk_val),
        .rob_full_i    (rob_full),
        .rob_tag_i     (rob_tag),
        .alloc_o       (alloc),
        .alloc_rd_o    (alloc_rd),
        .rs_busy_i     (rs_busy),
        .rs_load_o     (rs_load),
        .rs_op_o       (rs_op),
        .rs_vj_o       (rs_vj),
        .rs_vk_o       (rs_vk),
        .rs_qj_o       (rs_qj),
        .rs_qk_o       (rs_qk),
        .rs_tag_o      (rs_tag)
    );

    // rename happens on the same edge the rob entry is allocated
    regfile u_regfile (
        .clk            (clk),
        .rst            (rst),
        .load_tag_i     (alloc),
        .tag_rd_i       (alloc_rd),
        .tag_i          (rs_tag),
        .rs1_i          (rf_rs1),
        .rs2_i          (rf_rs2),
        .load_reg_i     (commit_valid_o),
        .commit_rd_i    (commit_rd_o),
        .commit_value_i (commit_value_o),
        .commit_tag_i   (commit_tag_o),
        .vj_o           (rf_vj),
        .vk_o           (rf_vk),
        .qj_o           (rf_qj),
        .qk_o           (rf_qk)
    );

    for (genvar i = 0; i < `NUM_RS; i++) begin : g_rs
        res_station u_rs (
            .clk         (clk),
            .rst         (rst),
            .load_i      (rs_load[i]),
            .op_i        (rs_op),
            .vj_i        (rs_vj),
            .vk_i        (rs_vk),
            .qj_i        (rs_qj),
            .qk_i        (rs_qk),
            .tag_i       (rs_tag),
            .cdb_valid_i (cdb_valid),
            .cdb_tag_i   (cdb_tag),
            .cdb_value_i (cdb_value),
            .grant_i     (grant[i]),
            .busy_o      (rs_busy[i]),
            .ready_o     (st_ready[i]),
            .result_o    (st_result[i]),
            .tag_o       (st_tag[i])
        );
    end

    rob u_rob (
        .clk            (clk),
        .rst            (rst),
        .alloc_i        (alloc),
        .alloc_rd_i     (alloc_rd),
        .tag_o          (rob_tag),
        .full_o         (rob_full),
        .qj_i           (rf_qj),
        .qk_i           (rf_qk),
        .qj_done_o      (rob_qj_done),
        .qk_done_o      (rob_qk_done),
        .qj_val_o       (rob_qj_val),
        .qk_val_o       (rob_qk_val),
        .st_ready_i     (st_ready),
        .st_result_i    (st_result),
        .st_tag_i       (st_tag),
        .grant_o        (grant),
        .cdb_valid_o    (cdb_valid),
        .cdb_tag_o      (cdb_tag),
        .cdb_value_o    (cdb_value),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_tag_o   (commit_tag_o),
        .commit_value_o (commit_value_o)
    );

endmodule : ooo_core

//--- hw/ooo_pkg.sv
`include "ooo_defines.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_AW-1:0] reg_id_t;
    typedef logic [`TAG_W-1:0] tag_t;

    // one bit per reservation station
    typedef logic [`NUM_RS-1:0] rs_sel_t;

    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5
    } alu_op_t;

    typedef enum logic [1:0] {
        ROB_FREE = 2'd0,
        ROB_WAIT = 2'd1,
        ROB_DONE = 2'd2
    } rob_state_t;

endpackage : ooo_pkg

//--- hw/regfile.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module regfile
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // rename from dispatch
    input  logic    load_tag_i,
    input  reg_id_t tag_rd_i,
    input  tag_t    tag_i,

    // dispatch operand lookup
    input  reg_id_t rs1_i,
    input  reg_id_t rs2_i,

    // commit from rob
    input  logic    load_reg_i,
    input  reg_id_t commit_rd_i,
    input  word_t   commit_value_i,
    input  tag_t    commit_tag_i,

    output word_t   vj_o,
    output word_t   vk_o,
    output tag_t    qj_o,
    output tag_t    qk_o
);

    localparam int NUM_REGS = 1 << `REG_AW;

    word_t regs_q [NUM_REGS];
    tag_t  tags_q [NUM_REGS];

    // x0 reads as a ready zero regardless of storage
    assign vj_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign vk_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];
    assign qj_o = (rs1_i == '0) ? '0 : tags_q[rs1_i];
    assign qk_o = (rs2_i == '0) ? '0 : tags_q[rs2_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
                tags_q[i] <= '0;
            end
        end else begin
            if (load_reg_i && commit_rd_i != '0) begin
                regs_q[commit_rd_i] <= commit_value_i;
                // a newer rename keeps its tag
                if (tags_q[commit_rd_i] == commit_tag_i) begin
                    tags_q[commit_rd_i] <= '0;
                end
            end
            // later assignment, so a new tag beats the clear above
            if (load_tag_i && tag_rd_i != '0) begin
                tags_q[tag_rd_i] <= tag_i;
            end
        end
    end

    // x0 storage never picks up a value or a rename
    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst)
        regs_q[0] == '0 && tags_q[0] == '0
    );

endmodule : regfile

//--- hw/res_station.sv
`timescale 1ns/1ps

module res_station
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // load from dispatch
    input  logic    load_i,
    input  alu_op_t op_i,
    input  word_t   vj_i,
    input  word_t   vk_i,
    input  tag_t    qj_i,
    input  tag_t    qk_i,
    input  tag_t    tag_i,

    // common data bus
    input  logic    cdb_valid_i,
    input  tag_t    cdb_tag_i,
    input  word_t   cdb_value_i,

    // rob arbitration
    input  logic    grant_i,

    output logic    busy_o,
    output logic    ready_o,
    output word_t   result_o,
    output tag_t    tag_o
);

    logic    busy_q;
    alu_op_t op_q;
    word_t   vj_q;
    word_t   vk_q;
    tag_t    qj_q;
    tag_t    qk_q;
    tag_t    tag_q;

    // bus hits on the incoming tags and on the held ones
    logic    in_hit_j;
    logic    in_hit_k;
    logic    held_hit_j;
    logic    held_hit_k;

    assign in_hit_j   = cdb_valid_i && qj_i != '0 && qj_i == cdb_tag_i;
    assign in_hit_k   = cdb_valid_i && qk_i != '0 && qk_i == cdb_tag_i;
    assign held_hit_j = cdb_valid_i && qj_q != '0 && qj_q == cdb_tag_i;
    assign held_hit_k = cdb_valid_i && qk_q != '0 && qk_q == cdb_tag_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            qj_q   <= '0;
            qk_q   <= '0;
        end else if (load_i) begin
            busy_q <= 1'b1;
            qj_q   <= in_hit_j ? '0 : qj_i;
            qk_q   <= in_hit_k ? '0 : qk_i;
        end else if (grant_i) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            if (held_hit_j) begin
                qj_q <= '0;
            end
            if (held_hit_k) begin
                qk_q <= '0;
            end
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        if (load_i) begin
            op_q  <= op_i;
            tag_q <= tag_i;
            vj_q  <= in_hit_j ? cdb_value_i : vj_i;
            vk_q  <= in_hit_k ? cdb_value_i : vk_i;
        end else begin
            if (held_hit_j) begin
                vj_q <= cdb_value_i;
            end
            if (held_hit_k) begin
                vk_q <= cdb_value_i;
            end
        end
    end

    always_comb begin
        unique case (op_q)
            OP_LI:   result_o = vj_q;
            OP_ADD:  result_o = vj_q + vk_q;
            OP_SUB:  result_o = vj_q - vk_q;
            OP_AND:  result_o = vj_q & vk_q;
            OP_OR:   result_o = vj_q | vk_q;
            OP_XOR:  result_o = vj_q ^ vk_q;
            default: result_o = '0;
        endcase
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q && qj_q == '0 && qk_q == '0;
    assign tag_o   = tag_q;

    // dispatch only targets free stations
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (rst) load_i |-> !busy_q
    );

    // rob only grants a station with both operands
    a_grant_ready: assert property (
        @(posedge clk) disable iff (rst) grant_i |-> ready_o
    );

endmodule : res_station

//--- hw/rob.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rob
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // allocation from dispatch
    input  logic    alloc_i,
    input  reg_id_t alloc_rd_i,
    output tag_t    tag_o,
    output logic    full_o,

    // dispatch operand lookups
    input  tag_t    qj_i,
    input  tag_t    qk_i,
    output logic    qj_done_o,
    output logic    qk_done_o,
    output word_t   qj_val_o,
    output word_t   qk_val_o,

    // stations
    input  rs_sel_t st_ready_i,
    input  word_t   st_result_i [`NUM_RS],
    input  tag_t    st_tag_i [`NUM_RS],
    output rs_sel_t grant_o,

    // common data bus
    output logic    cdb_valid_o,
    output tag_t    cdb_tag_o,
    output word_t   cdb_value_o,

    // in-order retire
    output logic    commit_valid_o,
    output reg_id_t commit_rd_o,
    output tag_t    commit_tag_o,
    output word_t   commit_value_o
);

    localparam int SLOT_W = $clog2(`ROB_DEPTH);

    typedef logic [SLOT_W-1:0] slot_t;

    rob_state_t state_q [`ROB_DEPTH];
    reg_id_t    rd_q    [`ROB_DEPTH];
    word_t      value_q [`ROB_DEPTH];

    slot_t         head_q;
    slot_t         tail_q;
    logic [SLOT_W:0] count_q;

    logic  grant_valid;
    tag_t  grant_tag;
    word_t grant_value;

    // tags run 1 .. ROB_DEPTH, slot is tag minus one
    function automatic slot_t slot_of(input tag_t t);
        tag_t idx;
        idx = t - tag_t'(1);
        return idx[SLOT_W-1:0];
    endfunction

    function automatic slot_t next_slot(input slot_t s);
        return (s == slot_t'(`ROB_DEPTH - 1)) ? '0 : s + slot_t'(1);
    endfunction

    assign tag_o  = tag_t'(tail_q) + tag_t'(1);
    assign full_o = (count_q == (SLOT_W+1)'(`ROB_DEPTH));

    assign qj_done_o = qj_i != '0 && state_q[slot_of(qj_i)] == ROB_DONE;
    assign qk_done_o = qk_i != '0 && state_q[slot_of(qk_i)] == ROB_DONE;
    assign qj_val_o  = value_q[slot_of(qj_i)];
    assign qk_val_o  = value_q[slot_of(qk_i)];

    // head retires as soon as its result is in
    assign commit_valid_o = (state_q[head_q] == ROB_DONE);
    assign commit_rd_o    = rd_q[head_q];
    assign commit_tag_o   = tag_t'(head_q) + tag_t'(1);
    assign commit_value_o = value_q[head_q];

    // fixed priority, lowest ready station wins
    always_comb begin
        grant_o     = '0;
        grant_valid = 1'b0;
        grant_tag   = '0;
        grant_value = '0;
        for (int i = 0; i < `NUM_RS; i++) begin
            if (st_ready_i[i] && !grant_valid) begin
                grant_valid = 1'b1;
                grant_o[i]  = 1'b1;
                grant_tag   = st_tag_i[i];
                grant_value = st_result_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ROB_FREE;
            end
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            cdb_valid_o <= 1'b0;
        end else begin
            // alloc, grant and commit always touch different slots
            if (alloc_i) begin
                state_q[tail_q] <= ROB_WAIT;
                tail_q          <= next_slot(tail_q);
            end
            if (grant_valid) begin
                state_q[slot_of(grant_tag)] <= ROB_DONE;
            end
            if (commit_valid_o) begin
                state_q[head_q] <= ROB_FREE;
                head_q          <= next_slot(head_q);
            end
            case ({alloc_i, commit_valid_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            cdb_valid_o <= grant_valid;
        end
    end

    // entry payload and bus data
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (grant_valid) begin
            value_q[slot_of(grant_tag)] <= grant_value;
            cdb_tag_o   <= grant_tag;
            cdb_value_o <= grant_value;
        end
    end

    // a station only finishes an instruction that is still outstanding
    a_grant_wait: assert property (
        @(posedge clk) disable iff (rst)
        grant_valid |-> state_q[slot_of(grant_tag)] == ROB_WAIT
    );

endmodule : rob

//--- include/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// data path width
`define XLEN 32

// architectural register address width, 32 registers
`define REG_AW 5

// rob tag width, tag 0 means no pending producer
`define TAG_W 4

// rob entries, tags 1 .. ROB_DEPTH
`define ROB_DEPTH 8

// number of reservation stations
`define NUM_RS 4

`endif

//--- list.f
+incdir+include
hw/ooo_pkg.sv
hw/regfile.sv
hw/dispatch.sv
hw/res_station.sv
hw/rob.sv
hw/ooo_core.sv
tests/ooo_core_tb.sv

//--- tests/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core_tb
    import ooo_pkg::*;
;

    localparam int TIMEOUT = 300;

    logic    clk;
    logic    rst;
    logic    issue_valid_i;
    alu_op_t issue_op_i;
    reg_id_t issue_rd_i;
    reg_id_t issue_rs1_i;
    reg_id_t issue_rs2_i;
    word_t   issue_imm_i;
    logic    issue_stall_o;
    logic    commit_valid_o;
    reg_id_t commit_rd_o;
    tag_t    commit_tag_o;
    word_t   commit_value_o;

    // architectural state as program order sees it
    word_t model_regs [32];

    // expected retire stream with the oldest at the front
    int    exp_rd_q [$];
    word_t exp_val_q [$];
    int    exp_tag_q [$];

    int    total_issued;
    int    commits_seen;
    int    checks;
    int    errors;
    string cur_test;

    ooo_core dut (
        .clk            (clk),
        .rst            (rst),
        .issue_valid_i  (issue_valid_i),
        .issue_op_i     (issue_op_i),
        .issue_rd_i     (issue_rd_i),
        .issue_rs1_i    (issue_rs1_i),
        .issue_rs2_i    (issue_rs2_i),
        .issue_imm_i    (issue_imm_i),
        .issue_stall_o  (issue_stall_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_tag_o   (commit_tag_o),
        .commit_value_o (commit_value_o)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_values(input string field, input logic [31:0] expected,
                                  input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h",
                     cur_test, field, expected, actual);
        end
    endtask

    // instruction semantics
    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b,
                                        input word_t imm);
        case (op)
            OP_LI:   return imm;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    // commit stream checker samples on the falling edge where commit_valid_o is settled
    always @(negedge clk) begin
        if (!rst && commit_valid_o) begin
            commits_seen++;
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("%s: commit of tag %0d with no instruction outstanding",
                         cur_test, commit_tag_o);
            end else begin
                compare_values("commit rd", exp_rd_q.pop_front(), commit_rd_o);
                compare_values("commit value", exp_val_q.pop_front(), commit_value_o);
                compare_values("commit tag", exp_tag_q.pop_front(), commit_tag_o);
            end
        end
    end

    // called 1 ns after a rising edge and returns at the same phase
    task automatic issue_task(input alu_op_t op, input int rd, input int rs1, input int rs2,
                              input word_t imm);
        int    wait_cycles;
        word_t result;
        wait_cycles = 0;
        while (issue_stall_o && wait_cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (issue_stall_o) begin
            errors++;
            $display("%s: issue stall stayed high for %0d cycles, instruction dropped",
                     cur_test, TIMEOUT);
        end else begin
            issue_valid_i = 1'b1;
            issue_op_i    = op;
            issue_rd_i    = reg_id_t'(rd);
            issue_rs1_i   = reg_id_t'(rs1);
            issue_rs2_i   = reg_id_t'(rs2);
            issue_imm_i   = imm;
            // reference model runs in program order and keeps x0 at zero
            result = alu_model(op, model_regs[rs1], model_regs[rs2], imm);
            if (rd != 0) begin
                model_regs[rd] = result;
            end
            exp_rd_q.push_back(rd);
            exp_val_q.push_back(result);
            // tags go out round robin starting at 1
            exp_tag_q.push_back((total_issued % `ROB_DEPTH) + 1);
            total_issued++;
            @(posedge clk);
            #1;
            issue_valid_i = 1'b0;
        end
    endtask

    task automatic wait_commits(input int target);
        int wait_cycles;
        wait_cycles = 0;
        while (commits_seen < target && wait_cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (commits_seen < target) begin
            errors++;
            $display("%s: only %0d of %0d commits arrived in time",
                     cur_test, commits_seen, target);
        end
    endtask

    task automatic drain_wait();
        int wait_cycles;
        wait_cycles = 0;
        while (exp_rd_q.size() != 0 && wait_cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (exp_rd_q.size() != 0) begin
            errors++;
            $display("%s: %0d commits still missing after %0d cycles",
                     cur_test, exp_rd_q.size(), TIMEOUT);
            exp_rd_q.delete();
            exp_val_q.delete();
            exp_tag_q.delete();
        end
    endtask

    task automatic idle_after_reset();
        int seen_before;
        cur_test = "reset_idle";
        compare_values("commit_valid_o", 0, commit_valid_o);
        compare_values("issue_stall_o", 0, issue_stall_o);
        seen_before = commits_seen;
        repeat (16) @(posedge clk);
        #1;
        // the monitor flags any stray commit and the count must not move
        compare_values("idle commits", seen_before, commits_seen);
        compare_values("idle stall", 0, issue_stall_o);
    endtask

    task automatic li_tag_wrap();
        cur_test = "li_stream";
        // ten entries so the tag sequence wraps past ROB_DEPTH
        for (int i = 1; i <= 10; i++) begin
            issue_task(OP_LI, i, 0, 0, 32'h1000_0000 + word_t'(i * 32'h0101));
        end
        drain_wait();
    endtask

    task automatic dependent_chain();
        cur_test = "dep_chain";
        issue_task(OP_LI, 1, 0, 0, 32'h0f0f_1234);
        issue_task(OP_LI, 2, 0, 0, 32'h3355_00ff);
        issue_task(OP_ADD, 3, 2, 1, '0);
        issue_task(OP_SUB, 4, 3, 1, '0);
        issue_task(OP_AND, 5, 4, 2, '0);
        issue_task(OP_OR, 6, 5, 3, '0);
        issue_task(OP_XOR, 7, 6, 4, '0);
        issue_task(OP_SUB, 8, 7, 2, '0);
        drain_wait();
    endtask

    task automatic x0_write_dropped();
        cur_test = "x0_write";
        issue_task(OP_LI, 0, 0, 0, 32'hdead_beef);
        issue_task(OP_LI, 9, 0, 0, 32'h0000_0055);
        // x0 contributes nothing to the sum
        issue_task(OP_ADD, 10, 0, 9, '0);
        issue_task(OP_OR, 11, 9, 0, '0);
        drain_wait();
    endtask

    task automatic waw_then_read();
        int target;
        cur_test = "waw_reader";
        issue_task(OP_LI, 5, 0, 0, 32'h0000_1111);
        issue_task(OP_LI, 5, 0, 0, 32'h0000_2222);
        issue_task(OP_ADD, 12, 5, 0, '0);
        drain_wait();
        // second writer depends on the first so it finishes later
        target = commits_seen + 1;
        issue_task(OP_LI, 5, 0, 0, 32'h0000_0011);
        issue_task(OP_ADD, 5, 5, 6, '0);
        wait_commits(target);
        issue_task(OP_OR, 13, 5, 0, '0);
        drain_wait();
    endtask

    task automatic random_stream();
        alu_op_t op;
        cur_test = "random_mix";
        for (int i = 0; i < 40; i++) begin
            op = alu_op_t'($urandom % 6);
            issue_task(op, 1 + ($urandom % 8), 1 + ($urandom % 8), 1 + ($urandom % 8),
                       $urandom);
        end
        drain_wait();
    endtask

    initial begin
        void'($urandom(32'hce7f_1fd0));
        rst           = 1'b1;
        issue_valid_i = 1'b0;
        issue_op_i    = OP_LI;
        issue_rd_i    = '0;
        issue_rs1_i   = '0;
        issue_rs2_i   = '0;
        issue_imm_i   = '0;
        total_issued  = 0;
        commits_seen  = 0;
        checks        = 0;
        errors        = 0;
        cur_test      = "reset";
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        idle_after_reset();
        li_tag_wrap();
        dependent_chain();
        x0_write_dropped();
        waw_then_read();
        random_stream();

        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d, commits: %0d", checks, errors, commits_seen);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : ooo_core_tb
